// ==== design/mips_config.svh ====
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath and instruction word width
`define MIPS_NBITS 32

// Register index width for 32 registers
`define MIPS_RNBITS 5
`define MIPS_NREGS (1 << `MIPS_RNBITS)

// Data memory depth in 32-bit words
`define MIPS_DMEM_WORDS 64

`endif

// ==== design/mips_pkg.sv ====
`include "mips_config.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_e;

    // R-type and I-type views of one instruction word
    typedef struct packed {
        logic [5:0]              opcode;
        logic [`MIPS_RNBITS-1:0] rs;
        logic [`MIPS_RNBITS-1:0] rt;
        logic [`MIPS_RNBITS-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } r_instr_t;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`MIPS_RNBITS-1:0] rs;
        logic [`MIPS_RNBITS-1:0] rt;
        logic [15:0]             imm;
    } i_instr_t;

    typedef union packed {
        r_instr_t r;
        i_instr_t i;
    } instr_u;

    // ALU op 00 adds, 01 subtracts and 10 follows funct
    typedef struct packed {
        logic       alu_src;
        logic [1:0] alu_op;
        logic       reg_dst;
    } ctrl_ex_t;

    typedef struct packed {
        logic branch;
        logic mem_write;
        logic mem_read;
    } ctrl_m_t;

    typedef struct packed {
        logic mem_to_reg;
        logic reg_write;
    } ctrl_wb_t;

    typedef struct packed {
        logic                    valid;
        logic [`MIPS_NBITS-1:0]  pc4;
        instr_u                  instr;
        logic [`MIPS_NBITS-1:0]  reg1;
        logic [`MIPS_NBITS-1:0]  reg2;
        logic [`MIPS_NBITS-1:0]  ext;
        logic [`MIPS_RNBITS-1:0] rt;
        logic [`MIPS_RNBITS-1:0] rd;
        ctrl_ex_t                ctrl_ex;
        ctrl_m_t                 ctrl_m;
        ctrl_wb_t                ctrl_wb;
    } id_ex_t;

    typedef struct packed {
        logic                    valid;
        logic [`MIPS_NBITS-1:0]  alu_result;
        logic [`MIPS_NBITS-1:0]  store_data;
        logic [`MIPS_RNBITS-1:0] dest;
        ctrl_m_t                 ctrl_m;
        ctrl_wb_t                ctrl_wb;
        logic                    branch_taken;
        logic [`MIPS_NBITS-1:0]  branch_target;
    } ex_mem_t;

    typedef struct packed {
        logic                    valid;
        logic [`MIPS_NBITS-1:0]  result;
        logic [`MIPS_RNBITS-1:0] dest;
        logic                    reg_write;
    } mem_wb_t;

    typedef struct packed {
        logic                   valid;
        logic                   taken;
        logic [`MIPS_NBITS-1:0] target;
    } branch_t;

endpackage

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module decode_stage
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_instr_valid,
    input  mips_pkg::instr_u       i_instr,
    input  logic [`MIPS_NBITS-1:0] i_pc4,
    input  mips_pkg::mem_wb_t      i_wb,
    output mips_pkg::id_ex_t       o_id_ex
);

    logic [`MIPS_NBITS-1:0]  regs [`MIPS_NREGS];

    logic                    known;
    mips_pkg::ctrl_ex_t      ctrl_ex;
    mips_pkg::ctrl_m_t       ctrl_m;
    mips_pkg::ctrl_wb_t      ctrl_wb;
    logic [`MIPS_RNBITS-1:0] dest;
    logic                    wb_en;
    logic [`MIPS_RNBITS-1:0] rs;
    logic [`MIPS_RNBITS-1:0] rt;
    logic [`MIPS_NBITS-1:0]  reg1;
    logic [`MIPS_NBITS-1:0]  reg2;

    assign rs = i_instr.i.rs;
    assign rt = i_instr.i.rt;

    // Main control
    always_comb
    begin
        known   = 1'b0;
        ctrl_ex = '0;
        ctrl_m  = '0;
        ctrl_wb = '0;
        case (i_instr.r.opcode)
            mips_pkg::OP_RTYPE:
            begin
                case (i_instr.r.funct)
                    mips_pkg::FN_ADD,
                    mips_pkg::FN_SUB,
                    mips_pkg::FN_AND,
                    mips_pkg::FN_OR,
                    mips_pkg::FN_SLT: known = 1'b1;
                    default:          known = 1'b0;
                endcase
                ctrl_ex.reg_dst   = 1'b1;
                ctrl_ex.alu_op    = 2'b10;
                ctrl_wb.reg_write = 1'b1;
            end
            mips_pkg::OP_ADDI:
            begin
                known             = 1'b1;
                ctrl_ex.alu_src   = 1'b1;
                ctrl_wb.reg_write = 1'b1;
            end
            mips_pkg::OP_LW:
            begin
                known              = 1'b1;
                ctrl_ex.alu_src    = 1'b1;
                ctrl_m.mem_read    = 1'b1;
                ctrl_wb.mem_to_reg = 1'b1;
                ctrl_wb.reg_write  = 1'b1;
            end
            mips_pkg::OP_SW:
            begin
                known            = 1'b1;
                ctrl_ex.alu_src  = 1'b1;
                ctrl_m.mem_write = 1'b1;
            end
            mips_pkg::OP_BEQ:
            begin
                known          = 1'b1;
                ctrl_ex.alu_op = 2'b01;
                ctrl_m.branch  = 1'b1;
            end
            default:
            begin
                known = 1'b0;
            end
        endcase

        dest = ctrl_ex.reg_dst ? i_instr.r.rd : rt;
        // Writes to $zero are dropped here so nothing downstream reports them
        if (dest == '0)
        begin
            ctrl_wb.reg_write = 1'b0;
        end

        // Bubble
        if (!(i_instr_valid && known))
        begin
            ctrl_ex = '0;
            ctrl_m  = '0;
            ctrl_wb = '0;
        end
    end

    // Register file with write-first reads
    assign wb_en = i_wb.valid && i_wb.reg_write && (i_wb.dest != '0);

    assign reg1 = (rs == '0) ? '0 :
                  (wb_en && (i_wb.dest == rs)) ? i_wb.result : regs[rs];
    assign reg2 = (rt == '0) ? '0 :
                  (wb_en && (i_wb.dest == rt)) ? i_wb.result : regs[rt];

    always_ff @(posedge i_clk)
    begin
        if (wb_en)
        begin
            regs[i_wb.dest] <= i_wb.result;
        end
    end

    assign o_id_ex.valid   = i_instr_valid && known;
    assign o_id_ex.pc4     = i_pc4;
    assign o_id_ex.instr   = i_instr;
    assign o_id_ex.reg1    = reg1;
    assign o_id_ex.reg2    = reg2;
    assign o_id_ex.ext     = {{(`MIPS_NBITS-16){i_instr.i.imm[15]}}, i_instr.i.imm};
    assign o_id_ex.rt      = rt;
    assign o_id_ex.rd      = i_instr.r.rd;
    assign o_id_ex.ctrl_ex = ctrl_ex;
    assign o_id_ex.ctrl_m  = ctrl_m;
    assign o_id_ex.ctrl_wb = ctrl_wb;

    // A writeback reaching the register file never targets $zero
    a_no_zero_write: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_wb.valid && i_wb.reg_write) |-> (i_wb.dest != '0)
    );

endmodule

// ==== design/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg
(
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  mips_pkg::id_ex_t i_id_ex,
    output mips_pkg::id_ex_t o_id_ex
);

    mips_pkg::id_ex_t id_ex_q;

    assign o_id_ex = id_ex_q;

    always_ff @(posedge i_clk)
    begin
        // Datapath fields
        id_ex_q.pc4   <= i_id_ex.pc4;
        id_ex_q.instr <= i_id_ex.instr;
        id_ex_q.reg1  <= i_id_ex.reg1;
        id_ex_q.reg2  <= i_id_ex.reg2;
        id_ex_q.ext   <= i_id_ex.ext;
        id_ex_q.rt    <= i_id_ex.rt;
        id_ex_q.rd    <= i_id_ex.rd;

        if (!i_rst_n)
        begin
            id_ex_q.valid   <= 1'b0;
            id_ex_q.ctrl_ex <= '0;
            id_ex_q.ctrl_m  <= '0;
            id_ex_q.ctrl_wb <= '0;
        end
        else
        begin
            id_ex_q.valid   <= i_id_ex.valid;
            id_ex_q.ctrl_ex <= i_id_ex.ctrl_ex;
            id_ex_q.ctrl_m  <= i_id_ex.ctrl_m;
            id_ex_q.ctrl_wb <= i_id_ex.ctrl_wb;
        end
    end

    // Bubbles carry no control into EX
    a_bubble_ctrl_zero: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !id_ex_q.valid |-> ((id_ex_q.ctrl_ex == '0) &&
                            (id_ex_q.ctrl_m == '0) &&
                            (id_ex_q.ctrl_wb == '0))
    );

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module execute_stage
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  mips_pkg::id_ex_t  i_id_ex,
    output mips_pkg::ex_mem_t o_ex_mem
);

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_SLT = 3'd4;

    logic [2:0]              alu_fn;
    logic [`MIPS_NBITS-1:0]  op_a;
    logic [`MIPS_NBITS-1:0]  op_b;
    logic [`MIPS_NBITS-1:0]  alu_result;
    logic [`MIPS_RNBITS-1:0] dest;
    logic                    taken;
    logic [`MIPS_NBITS-1:0]  target;

    mips_pkg::ex_mem_t       ex_mem_q;

    // ALU control
    always_comb
    begin
        case (i_id_ex.ctrl_ex.alu_op)
            2'b00:   alu_fn = ALU_ADD;
            2'b01:   alu_fn = ALU_SUB;
            default:
            begin
                case (i_id_ex.instr.r.funct)
                    mips_pkg::FN_SUB: alu_fn = ALU_SUB;
                    mips_pkg::FN_AND: alu_fn = ALU_AND;
                    mips_pkg::FN_OR:  alu_fn = ALU_OR;
                    mips_pkg::FN_SLT: alu_fn = ALU_SLT;
                    default:          alu_fn = ALU_ADD;
                endcase
            end
        endcase
    end

    assign op_a = i_id_ex.reg1;
    assign op_b = i_id_ex.ctrl_ex.alu_src ? i_id_ex.ext : i_id_ex.reg2;

    always_comb
    begin
        case (alu_fn)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT:
            begin
                alu_result = '0;
                alu_result[0] = ($signed(op_a) < $signed(op_b));
            end
            default: alu_result = op_a + op_b;
        endcase
    end

    assign dest = i_id_ex.ctrl_ex.reg_dst ? i_id_ex.rd : i_id_ex.rt;

    // Branch compare and target
    assign taken  = i_id_ex.ctrl_m.branch && (i_id_ex.reg1 == i_id_ex.reg2);
    assign target = i_id_ex.pc4 + {i_id_ex.ext[`MIPS_NBITS-3:0], 2'b00};

    always_ff @(posedge i_clk)
    begin
        ex_mem_q.alu_result    <= alu_result;
        ex_mem_q.store_data    <= i_id_ex.reg2;
        ex_mem_q.dest          <= dest;
        ex_mem_q.branch_target <= target;

        if (!i_rst_n)
        begin
            ex_mem_q.valid        <= 1'b0;
            ex_mem_q.ctrl_m       <= '0;
            ex_mem_q.ctrl_wb      <= '0;
            ex_mem_q.branch_taken <= 1'b0;
        end
        else
        begin
            ex_mem_q.valid        <= i_id_ex.valid;
            ex_mem_q.ctrl_m       <= i_id_ex.ctrl_m;
            ex_mem_q.ctrl_wb      <= i_id_ex.ctrl_wb;
            ex_mem_q.branch_taken <= taken;
        end
    end

    assign o_ex_mem = ex_mem_q;

endmodule

// ==== design/result_stage.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module result_stage
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  mips_pkg::ex_mem_t i_ex_mem,
    output mips_pkg::mem_wb_t o_mem_wb,
    output mips_pkg::branch_t o_branch
);

    localparam int DMEM_AW = $clog2(`MIPS_DMEM_WORDS);

    logic [`MIPS_NBITS-1:0] dmem [`MIPS_DMEM_WORDS];

    logic [DMEM_AW-1:0]     mem_idx;
    logic                   mem_we;
    logic [`MIPS_NBITS-1:0] load_data;
    logic [`MIPS_NBITS-1:0] wb_result;

    mips_pkg::mem_wb_t      mem_wb_q;
    mips_pkg::branch_t      branch_q;

    // Word index from the byte address bits above the offset
    assign mem_idx = i_ex_mem.alu_result[2 +: DMEM_AW];
    assign mem_we  = i_ex_mem.valid && i_ex_mem.ctrl_m.mem_write;

    always_ff @(posedge i_clk)
    begin
        if (mem_we)
        begin
            dmem[mem_idx] <= i_ex_mem.store_data;
        end
    end

    // Asynchronous read for loads
    assign load_data = dmem[mem_idx];
    assign wb_result = i_ex_mem.ctrl_wb.mem_to_reg ? load_data : i_ex_mem.alu_result;

    always_ff @(posedge i_clk)
    begin
        mem_wb_q.result <= wb_result;
        mem_wb_q.dest   <= i_ex_mem.dest;
        branch_q.target <= i_ex_mem.branch_target;

        if (!i_rst_n)
        begin
            mem_wb_q.valid     <= 1'b0;
            mem_wb_q.reg_write <= 1'b0;
            branch_q.valid     <= 1'b0;
            branch_q.taken     <= 1'b0;
        end
        else
        begin
            mem_wb_q.valid     <= i_ex_mem.valid;
            mem_wb_q.reg_write <= i_ex_mem.ctrl_wb.reg_write;
            branch_q.valid     <= i_ex_mem.valid && i_ex_mem.ctrl_m.branch;
            branch_q.taken     <= i_ex_mem.branch_taken;
        end
    end

    assign o_mem_wb = mem_wb_q;
    assign o_branch = branch_q;

    // Loads and stores stay inside the data memory
    a_dmem_in_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_ex_mem.valid && (i_ex_mem.ctrl_m.mem_read || i_ex_mem.ctrl_m.mem_write))
            |-> (i_ex_mem.alu_result[`MIPS_NBITS-1:2] < `MIPS_DMEM_WORDS)
    );

endmodule

// ==== design/mips_pipeline_top.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_pipeline_top
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_instr_valid,
    input  mips_pkg::instr_u        i_instr,
    input  logic [`MIPS_NBITS-1:0]  i_pc4,
    output logic                    o_wb_valid,
    output logic [`MIPS_RNBITS-1:0] o_wb_reg,
    output logic [`MIPS_NBITS-1:0]  o_wb_data,
    output logic                    o_br_valid,
    output logic                    o_br_taken,
    output logic [`MIPS_NBITS-1:0]  o_br_target
);

    mips_pkg::id_ex_t  id_ex_d;
    mips_pkg::id_ex_t  id_ex_q;
    mips_pkg::ex_mem_t ex_mem;
    mips_pkg::mem_wb_t mem_wb;
    mips_pkg::branch_t branch;

    decode_stage u_decode (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_pc4         (i_pc4),
        .i_wb          (mem_wb),
        .o_id_ex       (id_ex_d)
    );

    id_ex_reg u_id_ex (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_id_ex (id_ex_d),
        .o_id_ex (id_ex_q)
    );

    execute_stage u_execute (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_id_ex  (id_ex_q),
        .o_ex_mem (ex_mem)
    );

    result_stage u_result (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_ex_mem (ex_mem),
        .o_mem_wb (mem_wb),
        .o_branch (branch)
    );

    assign o_wb_valid  = mem_wb.valid && mem_wb.reg_write;
    assign o_wb_reg    = mem_wb.dest;
    assign o_wb_data   = mem_wb.result;
    assign o_br_valid  = branch.valid;
    assign o_br_taken  = branch.taken;
    assign o_br_target = branch.target;

endmodule

// ==== sim/tb_mips_pipeline.sv ====
`timescale 1ns/1ps
`include "mips_config.svh"

module tb_mips_pipeline;

    localparam int NUM_VECTORS      = 24;
    localparam int WORDS_PER_VECTOR = 9;
    localparam int LATENCY          = 3;
    localparam int TIMEOUT_NS       = NUM_VECTORS * 4 + 20 * 4;

    typedef struct packed {
        logic                    wb_valid;
        logic [`MIPS_RNBITS-1:0] wb_reg;
        logic [`MIPS_NBITS-1:0]  wb_data;
        logic                    br_valid;
        logic                    br_taken;
        logic [`MIPS_NBITS-1:0]  br_target;
    } expect_t;

    logic                    clk;
    logic                    rst_n;
    logic                    instr_valid;
    mips_pkg::instr_u        instr;
    logic [`MIPS_NBITS-1:0]  pc4;
    logic                    wb_valid;
    logic [`MIPS_RNBITS-1:0] wb_reg;
    logic [`MIPS_NBITS-1:0]  wb_data;
    logic                    br_valid;
    logic                    br_taken;
    logic [`MIPS_NBITS-1:0]  br_target;

    logic [31:0] vec_mem [NUM_VECTORS*WORDS_PER_VECTOR];
    expect_t     pending [$];

    mips_pipeline_top UUT (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .i_pc4         (pc4),
        .o_wb_valid    (wb_valid),
        .o_wb_reg      (wb_reg),
        .o_wb_data     (wb_data),
        .o_br_valid    (br_valid),
        .o_br_taken    (br_taken),
        .o_br_target   (br_target)
    );

    always
    begin
        #2 clk = ~clk;
    end

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want)
        else
        begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
            $display("Finished with errors");
            $fatal(1, "Output check failed");
        end
    endtask

    task automatic compare_outputs(input expect_t exp);
        check_field("o_wb_valid", wb_valid, exp.wb_valid);
        if (exp.wb_valid)
        begin
            check_field("o_wb_reg", wb_reg, exp.wb_reg);
            check_field("o_wb_data", wb_data, exp.wb_data);
        end
        check_field("o_br_valid", br_valid, exp.br_valid);
        if (exp.br_valid)
        begin
            check_field("o_br_taken", br_taken, exp.br_taken);
            check_field("o_br_target", br_target, exp.br_target);
        end
    endtask

    // Drives one issue slot and returns what it should produce
    task automatic apply_vector(input int idx, output expect_t exp);
        int base;
        base = idx * WORDS_PER_VECTOR;
        exp  = '0;
        if (idx < NUM_VECTORS)
        begin
            instr_valid   = vec_mem[base][0];
            pc4           = vec_mem[base+1];
            instr         = vec_mem[base+2];
            exp.wb_valid  = vec_mem[base+3][0];
            exp.wb_reg    = vec_mem[base+4][`MIPS_RNBITS-1:0];
            exp.wb_data   = vec_mem[base+5];
            exp.br_valid  = vec_mem[base+6][0];
            exp.br_taken  = vec_mem[base+7][0];
            exp.br_target = vec_mem[base+8];
        end
        else
        begin
            instr_valid = 1'b0;
            pc4         = '0;
            instr       = '0;
        end
    endtask

    initial
    begin
        expect_t exp;
        expect_t due;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc4         = '0;
        $readmemh("sim/pipeline_vectors.txt", vec_mem);

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_field("o_wb_valid after reset", wb_valid, 1'b0);
        check_field("o_br_valid after reset", br_valid, 1'b0);

        // Each slot is checked three cycles after it is driven
        for (int k = 0; k < NUM_VECTORS + LATENCY; k++)
        begin
            if (pending.size() == LATENCY)
            begin
                due = pending.pop_front();
                compare_outputs(due);
            end
            apply_vector(k, exp);
            pending.push_back(exp);
            @(posedge clk);
            #1;
        end

        $display("Finished with no errors");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not complete within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== project.f ====
+incdir+design
design/mips_pkg.sv
design/decode_stage.sv
design/id_ex_reg.sv
design/execute_stage.sv
design/result_stage.sv
design/mips_pipeline_top.sv
sim/tb_mips_pipeline.sv

// ==== Makefile ====
TOP := tb_mips_pipeline

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only --timing -Wall -f project.f \
		--top-module mips_pipeline_top

clean:
	rm -rf obj_dir

// ==== sim/pipeline_vectors.txt ====
// Columns: valid pc4 instr wb_valid wb_reg wb_data br_valid br_taken br_target
// One issue slot per line, all fields hex
0 00000000 00000000 0 00 00000000 0 0 00000000 // idle
0 00000000 00000000 0 00 00000000 0 0 00000000 // idle
1 00000004 20010005 1 01 00000005 0 0 00000000 // addi $1,$0,5
1 00000008 2002FFFD 1 02 FFFFFFFD 0 0 00000000 // addi $2,$0,-3
1 0000000C 2003000C 1 03 0000000C 0 0 00000000 // addi $3,$0,12
1 00000010 20040040 1 04 00000040 0 0 00000000 // addi $4,$0,0x40
1 00000014 00222820 1 05 00000002 0 0 00000000 // add $5,$1,$2
1 00000018 00233022 1 06 FFFFFFF9 0 0 00000000 // sub $6,$1,$3
1 0000001C 00233824 1 07 00000004 0 0 00000000 // and $7,$1,$3
1 00000020 00234025 1 08 0000000D 0 0 00000000 // or $8,$1,$3
1 00000024 0041482A 1 09 00000001 0 0 00000000 // slt $9,$2,$1
1 00000028 0022502A 1 0A 00000000 0 0 00000000 // slt $10,$1,$2
1 0000002C AC860008 0 00 00000000 0 0 00000000 // sw $6,8($4)
1 00000030 FC221234 0 00 00000000 0 0 00000000 // unknown opcode
1 00000034 20000063 0 00 00000000 0 0 00000000 // addi $0,$0,99
1 00000038 8C8B0008 1 0B FFFFFFF9 0 0 00000000 // lw $11,8($4)
1 0000003C 10210003 0 00 00000000 1 1 00000048 // beq $1,$1,3
1 00000040 1022FFFE 0 00 00000000 1 0 00000038 // beq $1,$2,-2
1 00000044 00016020 1 0C 00000005 0 0 00000000 // add $12,$0,$1
1 00000048 AC810000 0 00 00000000 0 0 00000000 // sw $1,0($4)
1 0000004C 00A77024 1 0E 00000000 0 0 00000000 // and $14,$5,$7
1 00000050 8C8D0000 1 0D 00000005 0 0 00000000 // lw $13,0($4)
1 00000054 11400001 0 00 00000000 1 1 00000058 // beq $10,$0,1
0 00000000 00000000 0 00 00000000 0 0 00000000 // idle
